/* hdl/array_pkg.sv */
package array_pkg;

  // ##############################
  // array size and pwm timing
  // ##############################

  localparam int num_trans = 4;
  localparam int period = 512;  // cycles in one pwm period
  localparam int cnt_w = 9;
  localparam int idx_w = 2;
  localparam int cmd_data_w = 16;

  // last value of the time count before it wraps to 0
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(period - 1);

  // ##############################
  // data types
  // ##############################

  typedef logic [idx_w-1:0] idx_t;
  typedef logic [7:0] intensity_t;
  typedef logic [7:0] phase_t;  // one step is two cycles of the period
  typedef logic [cnt_w-1:0] pulse_width_t;

  localparam idx_t last_idx = idx_t'(num_trans - 1);

  // full gain and an unlimited silencer step until the host says otherwise
  localparam intensity_t gain_reset = 8'hff;
  localparam intensity_t step_reset = 8'hff;

  // ##############################
  // host commands and pipeline states
  // ##############################

  typedef enum logic [1:0] {
    op_nop       = 2'd0,
    op_set_drive = 2'd1,  // data high byte is intensity, low byte is phase
    op_set_gain  = 2'd2,
    op_set_step  = 2'd3
  } opcode_t;

  typedef enum logic {
    st_idle = 1'b0,
    st_run  = 1'b1
  } pipe_state_t;

endpackage

/* hdl/drive_settings_if.sv */
`timescale 1ns/1ps

// decoded host settings plus the write port of the drive table
interface drive_settings_if;

  array_pkg::intensity_t mod_gain;
  array_pkg::intensity_t silencer_step;

  logic table_we;  // single cycle strobe
  array_pkg::idx_t table_idx;
  array_pkg::intensity_t table_intensity;
  array_pkg::phase_t table_phase;

  modport decoder(
    output mod_gain, silencer_step,
    output table_we, table_idx, table_intensity, table_phase
  );

  modport pipeline(
    input mod_gain, silencer_step,
    input table_we, table_idx, table_intensity, table_phase
  );

endinterface

/* hdl/drive_bus_if.sv */
`timescale 1ns/1ps

// one item per transducer per pass, no back-pressure
interface drive_bus_if;

  logic valid;
  array_pkg::idx_t idx;
  array_pkg::pulse_width_t pulse_width;
  array_pkg::phase_t phase;

  modport source(
    output valid, idx, pulse_width, phase
  );

  modport sink(
    input valid, idx, pulse_width, phase
  );

endinterface

/* hdl/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder (
  input logic CLK,
  input logic reset,
  input logic cmd_valid,
  input array_pkg::opcode_t cmd_op,
  input array_pkg::idx_t cmd_addr,
  input logic [array_pkg::cmd_data_w-1:0] cmd_data,
  drive_settings_if.decoder settings
);

  array_pkg::intensity_t data_hi;
  logic [7:0] data_lo;
  logic is_drive;

  assign data_hi = cmd_data[15:8];
  assign data_lo = cmd_data[7:0];
  assign is_drive = cmd_valid && (cmd_op == array_pkg::op_set_drive);

  // ##############################
  // global registers and write strobe
  // ##############################

  always_ff @(posedge CLK) begin
    if (reset) begin
      settings.mod_gain <= array_pkg::gain_reset;
      settings.silencer_step <= array_pkg::step_reset;
      settings.table_we <= 1'b0;
    end else begin
      settings.table_we <= 1'b0;  // strobe lasts a single cycle
      if (cmd_valid) begin
        case (cmd_op)
          array_pkg::op_set_drive: begin
            settings.table_we <= 1'b1;
          end
          array_pkg::op_set_gain: begin
            settings.mod_gain <= data_lo;
          end
          array_pkg::op_set_step: begin
            settings.silencer_step <= data_lo;
          end
          default: begin
            // nop leaves everything as it is
          end
        endcase
      end
    end
  end

  // ##############################
  // table write payload
  // ##############################

  // only meaningful while table_we is high
  always_ff @(posedge CLK) begin
    if (is_drive) begin
      settings.table_idx <= cmd_addr;
      settings.table_intensity <= data_hi;
      settings.table_phase <= data_lo;
    end
  end

endmodule

/* hdl/time_cnt_generator.sv */
`timescale 1ns/1ps

module time_cnt_generator (
  input logic CLK,
  input logic reset,
  output logic [array_pkg::cnt_w-1:0] time_cnt,
  output logic update
);

  logic at_wrap;

  assign at_wrap = (time_cnt == array_pkg::last_cnt);

  always_ff @(posedge CLK) begin
    if (reset) begin
      time_cnt <= '0;
    end else if (at_wrap) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 1'b1;
    end
  end

  // registered next to the counter so both line up on count 0
  always_ff @(posedge CLK) begin
    if (reset) begin
      update <= 1'b0;
    end else begin
      update <= at_wrap;
    end
  end

endmodule

/* hdl/drive_pipeline.sv */
`timescale 1ns/1ps

module drive_pipeline (
  input logic CLK,
  input logic reset,
  input logic update,
  drive_settings_if.pipeline settings,
  drive_bus_if.source drive
);

  array_pkg::intensity_t table_intensity [array_pkg::num_trans];
  array_pkg::phase_t table_phase [array_pkg::num_trans];
  array_pkg::intensity_t sil_state [array_pkg::num_trans];

  array_pkg::pipe_state_t state;
  array_pkg::idx_t seq_idx;
  logic issue;
  array_pkg::idx_t issue_idx;

  logic s1_valid;
  array_pkg::idx_t s1_idx;
  array_pkg::intensity_t s1_intensity;
  array_pkg::phase_t s1_phase;

  logic [15:0] product;
  logic [15:0] scaled_sum;

  logic s2_valid;
  array_pkg::idx_t s2_idx;
  array_pkg::intensity_t s2_target;
  array_pkg::phase_t s2_phase;

  array_pkg::intensity_t cur;
  array_pkg::intensity_t diff;
  array_pkg::intensity_t next;

  // ##############################
  // drive table
  // ##############################

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < array_pkg::num_trans; i++) begin
        table_intensity[i] <= '0;
        table_phase[i] <= '0;
      end
    end else if (settings.table_we) begin
      table_intensity[settings.table_idx] <= settings.table_intensity;
      table_phase[settings.table_idx] <= settings.table_phase;
    end
  end

  // ##############################
  // sequencer
  // ##############################

  // item 0 is read in the update cycle itself, the rest follow back to back
  assign issue = update || (state == array_pkg::st_run);
  assign issue_idx = (state == array_pkg::st_run) ? seq_idx : '0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= array_pkg::st_idle;
      seq_idx <= '0;
    end else begin
      case (state)
        array_pkg::st_idle: begin
          if (update) begin
            state <= array_pkg::st_run;
            seq_idx <= 2'd1;
          end
        end
        array_pkg::st_run: begin
          if (seq_idx == array_pkg::last_idx) state <= array_pkg::st_idle;
          seq_idx <= seq_idx + 1'b1;  // wraps back to 0 at the end of a pass
        end
        default: state <= array_pkg::st_idle;
      endcase
    end
  end

  // ##############################
  // stage 1: table read
  // ##############################

  always_ff @(posedge CLK) begin
    if (reset) s1_valid <= 1'b0;
    else s1_valid <= issue;
  end

  always_ff @(posedge CLK) begin
    s1_idx <= issue_idx;
    s1_intensity <= table_intensity[issue_idx];
    s1_phase <= table_phase[issue_idx];
  end

  // ##############################
  // stage 2: gain scaling
  // ##############################

  // floor(x / 255) as (x + x/256 + 1) / 256, the sum tops out at 65280
  assign product = s1_intensity * settings.mod_gain;
  assign scaled_sum = product + product[15:8] + 16'd1;

  always_ff @(posedge CLK) begin
    if (reset) s2_valid <= 1'b0;
    else s2_valid <= s1_valid;
  end

  always_ff @(posedge CLK) begin
    s2_idx <= s1_idx;
    s2_target <= scaled_sum[15:8];
    s2_phase <= s1_phase;
  end

  // ##############################
  // stage 3: silencer and pulse width
  // ##############################

  always_comb begin
    cur = sil_state[s2_idx];
    if (s2_target > cur) begin
      diff = s2_target - cur;
      next = (diff > settings.silencer_step) ? cur + settings.silencer_step : s2_target;
    end else begin
      diff = cur - s2_target;
      next = (diff > settings.silencer_step) ? cur - settings.silencer_step : s2_target;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < array_pkg::num_trans; i++) sil_state[i] <= '0;
    end else if (s2_valid) begin
      sil_state[s2_idx] <= next;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) drive.valid <= 1'b0;
    else drive.valid <= s2_valid;
  end

  // width is the slewed value itself, so never more than half the period
  always_ff @(posedge CLK) begin
    drive.idx <= s2_idx;
    drive.pulse_width <= array_pkg::pulse_width_t'(next);
    drive.phase <= s2_phase;
  end

endmodule

/* hdl/pwm_generator.sv */
`timescale 1ns/1ps

module pwm_generator (
  input logic CLK,
  input logic reset,
  input logic [array_pkg::cnt_w-1:0] time_cnt,
  input logic update,
  drive_bus_if.sink drive,
  output logic [array_pkg::num_trans-1:0] pwm_out
);

  array_pkg::pulse_width_t shadow_pw [array_pkg::num_trans];
  array_pkg::phase_t shadow_ph [array_pkg::num_trans];
  array_pkg::pulse_width_t active_pw [array_pkg::num_trans];
  array_pkg::phase_t active_ph [array_pkg::num_trans];

  array_pkg::pulse_width_t sel_pw [array_pkg::num_trans];
  array_pkg::phase_t sel_ph [array_pkg::num_trans];
  logic [array_pkg::cnt_w-1:0] offset [array_pkg::num_trans];
  logic [array_pkg::num_trans-1:0] line;

  // ##############################
  // shadow and active buffers
  // ##############################

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < array_pkg::num_trans; i++) begin
        shadow_pw[i] <= '0;
        shadow_ph[i] <= '0;
        active_pw[i] <= '0;
        active_ph[i] <= '0;
      end
    end else begin
      if (drive.valid) begin
        shadow_pw[drive.idx] <= drive.pulse_width;
        shadow_ph[drive.idx] <= drive.phase;
      end
      if (update) begin
        active_pw <= shadow_pw;  // swap at the period boundary
        active_ph <= shadow_ph;
      end
    end
  end

  // ##############################
  // pwm lines
  // ##############################

  // in the update cycle the shadow values already belong to the new period
  always_comb begin
    for (int i = 0; i < array_pkg::num_trans; i++) begin
      sel_pw[i] = update ? shadow_pw[i] : active_pw[i];
      sel_ph[i] = update ? shadow_ph[i] : active_ph[i];
      offset[i] = time_cnt - {sel_ph[i], 1'b0};  // modulo the period
      line[i] = offset[i] < sel_pw[i];
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) pwm_out <= '0;
    else pwm_out <= line;
  end

endmodule

/* hdl/array_driver.sv */
`timescale 1ns/1ps

module array_driver (
  input logic CLK,
  input logic reset,
  input logic cmd_valid,
  input array_pkg::opcode_t cmd_op,
  input array_pkg::idx_t cmd_addr,
  input logic [array_pkg::cmd_data_w-1:0] cmd_data,
  output logic [array_pkg::num_trans-1:0] pwm_out,
  output logic period_start
);

  drive_settings_if settings_if ();
  drive_bus_if drive_if ();

  logic [array_pkg::cnt_w-1:0] time_cnt;

  cmd_decoder cmd_decoder (
    .CLK(CLK),
    .reset(reset),
    .cmd_valid(cmd_valid),
    .cmd_op(cmd_op),
    .cmd_addr(cmd_addr),
    .cmd_data(cmd_data),
    .settings(settings_if.decoder)
  );

  // the period update pulse is brought straight out as period_start
  time_cnt_generator time_cnt_generator (
    .CLK(CLK),
    .reset(reset),
    .time_cnt(time_cnt),
    .update(period_start)
  );

  drive_pipeline drive_pipeline (
    .CLK(CLK),
    .reset(reset),
    .update(period_start),
    .settings(settings_if.pipeline),
    .drive(drive_if.source)
  );

  pwm_generator pwm_generator (
    .CLK(CLK),
    .reset(reset),
    .time_cnt(time_cnt),
    .update(period_start),
    .drive(drive_if.sink),
    .pwm_out(pwm_out)
  );

endmodule

/* tb/array_driver_asserts.sv */
`timescale 1ns/1ps

module array_driver_asserts (
  input logic CLK,
  input logic reset,
  input logic update,
  input array_pkg::pipe_state_t state,
  input logic valid,
  input array_pkg::idx_t idx
);

  int run_len;  // earlier cycles in a row with valid high

  always_ff @(posedge CLK) begin
    if (reset) run_len <= 0;
    else if (valid) run_len <= run_len + 1;
    else run_len <= 0;
  end

  // one pass puts out exactly one item per transducer
  valid_burst_len: assert property (@(posedge CLK) disable iff (reset)
    valid |-> run_len < array_pkg::num_trans)
    else $error("drive.valid stayed high for more than %0d cycles", array_pkg::num_trans);

  pass_starts_at_zero: assert property (@(posedge CLK) disable iff (reset)
    valid && !$past(valid) |-> idx == '0)
    else $error("a pass started at index %0d instead of 0", idx);

  idx_steps_by_one: assert property (@(posedge CLK) disable iff (reset)
    valid && $past(valid) |-> idx == array_pkg::idx_t'($past(idx) + 1'b1))
    else $error("drive.idx did not step by one between items");

  idle_at_update: assert property (@(posedge CLK) disable iff (reset)
    update |-> state == array_pkg::st_idle)
    else $error("pipeline was still busy when the next period started");

endmodule

bind drive_pipeline array_driver_asserts asserts (
  .CLK(CLK),
  .reset(reset),
  .update(update),
  .state(state),
  .valid(drive.valid),
  .idx(drive.idx)
);

/* tb/array_driver_tb.sv */
`timescale 1ns/1ps

module array_driver_tb;

  localparam int timeout_cycles = 2000;
  localparam int rec_words = 5;  // kind plus four fields
  localparam int max_words = 160;

  logic CLK;
  logic reset;
  logic cmd_valid;
  array_pkg::opcode_t cmd_op;
  array_pkg::idx_t cmd_addr;
  logic [array_pkg::cmd_data_w-1:0] cmd_data;
  logic [array_pkg::num_trans-1:0] pwm_out;
  logic period_start;

  logic [15:0] stim [max_words];
  int num_checks;

  array_driver dut (
    .CLK(CLK),
    .reset(reset),
    .cmd_valid(cmd_valid),
    .cmd_op(cmd_op),
    .cmd_addr(cmd_addr),
    .cmd_data(cmd_data),
    .pwm_out(pwm_out),
    .period_start(period_start)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // ##############################
  // failure handling and compares
  // ##############################

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pulse_width(input string name, input array_pkg::pulse_width_t got,
                                   input array_pkg::pulse_width_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_phase(input string name, input array_pkg::phase_t got,
                             input array_pkg::phase_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_period_start(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: period_start is %b, expected %b",
                          $time, got, exp));
    end
  endtask

  // ##############################
  // stimulus and measurement
  // ##############################

  task automatic send_cmd(input array_pkg::opcode_t op, input array_pkg::idx_t addr,
                          input logic [array_pkg::cmd_data_w-1:0] data);
    @(posedge CLK);
    cmd_valid <= 1'b1;
    cmd_op <= op;
    cmd_addr <= addr;
    cmd_data <= data;
    @(posedge CLK);
    cmd_valid <= 1'b0;
  endtask

  // returns on the falling edge of the cycle that carries the last pulse
  task automatic wait_period_starts(input int count);
    int waited;
    for (int i = 0; i < count; i++) begin
      waited = 0;
      @(negedge CLK);
      while (!period_start) begin
        waited++;
        if (waited >= timeout_cycles) begin
          abort_run($sformatf("period_start did not come within %0d cycles", timeout_cycles));
        end
        @(negedge CLK);
      end
    end
  endtask

  task automatic measure_period(input array_pkg::idx_t trans,
                                output array_pkg::pulse_width_t high_cnt, output int rise_at);
    logic [array_pkg::period-1:0] seen;
    int ones;
    int prev;
    wait_period_starts(1);
    for (int k = 0; k < array_pkg::period; k++) begin
      @(negedge CLK);
      seen[k] = pwm_out[trans];  // pwm_out lags the count by one cycle
      check_period_start(period_start, k == array_pkg::period - 1);  // one pulse per period
    end
    ones = 0;
    rise_at = -1;
    for (int k = 0; k < array_pkg::period; k++) begin
      prev = (k + array_pkg::period - 1) % array_pkg::period;
      if (seen[k]) ones++;
      if (rise_at < 0 && seen[k] && !seen[prev]) rise_at = k;
    end
    if (ones == array_pkg::period) begin
      abort_run($sformatf("pwm_out[%0d] stayed high for a whole period", trans));
    end
    high_cnt = array_pkg::pulse_width_t'(ones);
  endtask

  // ##############################
  // main sequence
  // ##############################

  initial begin
    int pos;
    int kind;
    int rise_at;
    bit done;
    array_pkg::idx_t trans;
    array_pkg::pulse_width_t exp_pw;
    array_pkg::phase_t exp_ph;
    array_pkg::pulse_width_t got_pw;

    reset <= 1'b1;
    cmd_valid <= 1'b0;
    cmd_op <= array_pkg::op_nop;
    cmd_addr <= '0;
    cmd_data <= '0;
    num_checks = 0;
    for (int i = 0; i < max_words; i++) stim[i] = '0;  // unread words read as the end record
    $readmemh("tb/stim_input.txt", stim);

    repeat (4) @(posedge CLK);
    reset <= 1'b0;

    pos = 0;
    done = 1'b0;
    while (!done && pos + rec_words <= max_words) begin
      kind = int'(stim[pos]);
      case (kind)
        1: begin
          send_cmd(array_pkg::opcode_t'(stim[pos+1][1:0]), array_pkg::idx_t'(stim[pos+2]),
                   stim[pos+3]);
        end
        2: begin
          trans = array_pkg::idx_t'(stim[pos+1]);
          exp_pw = array_pkg::pulse_width_t'(stim[pos+2]);
          exp_ph = array_pkg::phase_t'(stim[pos+3]);
          wait_period_starts(int'(stim[pos+4]));
          measure_period(trans, got_pw, rise_at);
          check_pulse_width($sformatf("pulse width of pwm_out[%0d]", trans), got_pw, exp_pw);
          if (exp_pw != 0) begin
            // rising edge sits at twice the phase
            if (rise_at < 0 || rise_at % 2 != 0) begin
              abort_run($sformatf("pwm_out[%0d] has no rising edge at an even count", trans));
            end
            check_phase($sformatf("phase of pwm_out[%0d]", trans),
                        array_pkg::phase_t'(rise_at / 2), exp_ph);
          end
          num_checks++;
        end
        default: done = 1'b1;
      endcase
      pos += rec_words;
    end

    if (num_checks > 0) begin
      $display("PASS: all tests");
    end else begin
      abort_run("no check records were found in the stimulus file");
    end
    $finish;
  end

endmodule

/* tb/stim_input.txt */
// five hex words per record: kind then four fields, kind 0 ends the list
// kind 1 command: op addr data 0 / kind 2 check: trans width phase settle_periods
2 0 0 0 0
2 1 0 0 0
2 2 0 0 0
2 3 0 0 0
1 1 0 c800 0
2 0 c8 0 1
1 1 1 6440 0
1 1 2 96c8 0
2 1 64 40 1
2 2 96 c8 0
2 0 c8 0 0
1 2 0 0080 0
2 0 64 0 1
2 1 32 40 0
2 2 4b c8 0
1 2 0 00ff 0
1 3 0 0010 0
1 1 3 a000 0
2 3 30 0 3
2 3 a0 0 7
2 0 c8 0 0
2 1 64 40 0
0 0 0 0 0

/* vlog.f */
hdl/array_pkg.sv
hdl/drive_settings_if.sv
hdl/drive_bus_if.sv
hdl/cmd_decoder.sv
hdl/time_cnt_generator.sv
hdl/drive_pipeline.sv
hdl/pwm_generator.sv
hdl/array_driver.sv
tb/array_driver_asserts.sv
tb/array_driver_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
log=sim.log
{ verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module array_driver_tb \
    -o array_driver_sim && ./obj_dir/array_driver_sim; } > "$log" 2>&1 \
  || echo "FAIL: see errors above" >> "$log"
cat "$log"
grep -q "FAIL: see errors above" "$log" && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
